// ==== list.f ====
+incdir+rtl
rtl/decodePkg.sv
rtl/instDecoder.sv
rtl/immGen.sv
rtl/branchUnit.sv
rtl/stageHandshake.sv
rtl/decodeReg.sv
rtl/decodeStage.sv
tests/decode_asserts.sv
tests/decodeTb.sv

// ==== rtl/branchUnit.sv ====
`timescale 1ns/1ns
`include "rv64_macros.svh"

module branchUnit (
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      rs1Data,
    input  logic [`XLEN-1:0]      rs2Data,
    input  logic [`XLEN-1:0]      imm,
    input  logic [`INST_W-1:0]    inst,
    input  decodePkg::decodeCtrlT ctrl,
    output logic [`XLEN-1:0]      nextPc
);
    import decodePkg::*;

    logic [2:0]       funct3;
    logic             taken;
    logic [`XLEN-1:0] seqPc;
    logic [`XLEN-1:0] jalrSum;

    assign funct3  = inst[14:12];
    assign seqPc   = pc + `XLEN'(`PC_STEP);
    assign jalrSum = rs1Data + imm;

    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1Data == rs2Data);
            3'b001:  taken = (rs1Data != rs2Data);
            3'b100:  taken = ($signed(rs1Data) < $signed(rs2Data));
            3'b101:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            3'b110:  taken = (rs1Data < rs2Data);
            3'b111:  taken = (rs1Data >= rs2Data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.flow)
            FlowBranch: nextPc = taken ? pc + imm : seqPc;
            FlowJal:    nextPc = pc + imm;
            FlowJalr:   nextPc = {jalrSum[`XLEN-1:1], 1'b0}; // Target LSB dropped
            default:    nextPc = seqPc;
        endcase
    end

endmodule

// ==== rtl/decodePkg.sv ====
`include "rv64_macros.svh"

package decodePkg;

    typedef enum logic [`OPCODE_W-1:0] {
        OpLoad   = 7'b0000011,
        OpI      = 7'b0010011,
        OpAuipc  = 7'b0010111,
        OpIW     = 7'b0011011,
        OpStore  = 7'b0100011,
        OpR      = 7'b0110011,
        OpLui    = 7'b0110111,
        OpRW     = 7'b0111011,
        OpBranch = 7'b1100011,
        OpJalr   = 7'b1100111,
        OpJal    = 7'b1101111,
        OpSystem = 7'b1110011
    } opcodeT;

    typedef enum logic [4:0] {
        ExeNop, Add, Sub, Sll, Srl, Sra, Xor, Or, And, Slt, Sltu,
        Mul, Mulh, Mulhsu, Mulhu, Div, Divu, Rem, Remu,
        Addw, Subw, Sllw, Srlw, Sraw, Mulw, Divw, Divuw, Remw, Remuw
    } exeOpT;

    typedef enum logic [1:0] {SrcNone, SrcRegReg, SrcRegImm, SrcPcImm} exeSrcT;

    typedef enum logic [3:0] {
        MemNop, Lb, Lh, Lw, Ld, Lbu, Lhu, Lwu, Sb, Sh, Sw, Sd
    } memOpT;

    // Five sources, so three bits
    typedef enum logic [2:0] {WbNone, WbExe, WbMem, WbImm, WbNextPc} wbSelT;

    typedef enum logic [1:0] {FlowSeq, FlowBranch, FlowJal, FlowJalr} flowT;

    typedef enum logic [3:0] {TrapNone, TrapIllegal, TrapEcall, TrapEbreak, TrapMret} trapT;

    typedef enum logic [2:0] {FmtNone, FmtI, FmtS, FmtB, FmtU, FmtJ} immFmtT;

    typedef struct packed {
        exeOpT  exeOp;
        exeSrcT exeSrc;
        memOpT  memOp;
        wbSelT  wbSel;
        flowT   flow;
        immFmtT immFmt;
        trapT   trap;
    } decodeCtrlT;

    // Item handed to execute
    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        exeOpT                  exeOp;
        exeSrcT                 exeSrc;
        memOpT                  memOp;
        wbSelT                  wbSel;
        trapT                   trap;
    } stageOutT;

endpackage

// ==== rtl/decodeReg.sv ====
`timescale 1ns/1ns
`include "rv64_macros.svh"

module decodeReg (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  accept,
    input  logic                  exeReady,
    input  logic [`INST_W-1:0]    inst,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      imm,
    input  decodePkg::decodeCtrlT ctrl,
    input  decodePkg::trapT       trapIn,
    output decodePkg::stageOutT   stageOut
);
    import decodePkg::*;

    stageOutT nextItem;
    stageOutT itemQ;
    logic     validQ;

    always_comb begin
        nextItem.valid  = accept;
        nextItem.pc     = pc;
        nextItem.imm    = imm;
        nextItem.rd     = inst[11:7];
        nextItem.rs1    = inst[19:15];
        nextItem.rs2    = inst[24:20];
        nextItem.exeOp  = ctrl.exeOp;
        nextItem.exeSrc = ctrl.exeSrc;
        nextItem.memOp  = ctrl.memOp;
        nextItem.wbSel  = ctrl.wbSel;
        nextItem.trap   = ctrl.trap;
        if (trapIn != TrapNone) begin // Fetch trap overrides decode and disables the op
            nextItem.exeOp  = ExeNop;
            nextItem.exeSrc = SrcNone;
            nextItem.memOp  = MemNop;
            nextItem.wbSel  = WbNone;
            nextItem.trap   = trapIn;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Valid bit, advances only when execute takes the slot
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (exeReady) begin
            validQ <= accept; // Bubble when nothing accepted
        end
    end

    always_ff @(posedge clk) begin
        if (exeReady && accept) begin
            itemQ <= nextItem;
        end
    end

    always_comb begin
        stageOut       = itemQ;
        stageOut.valid = validQ;
    end

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/1ns
`include "rv64_macros.svh"

module decodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`INST_W-1:0]     inst,
    input  logic                   inValid,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       rs1Data,
    input  logic [`XLEN-1:0]       rs2Data,
    input  decodePkg::trapT        trapIn,
    input  logic                   conflict,
    input  logic                   flush,
    input  logic                   ifReady,
    input  logic                   exeReady,
    output logic [`REG_ADDR_W-1:0] rs1Addr,
    output logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic                   ready,
    output logic                   redirect,
    output logic [`XLEN-1:0]       nextPc,
    output decodePkg::stageOutT    stageOut
);
    import decodePkg::*;

    decodeCtrlT       ctrl;
    logic [`XLEN-1:0] imm;
    logic             accept;

    // Register file read ports
    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];

    instDecoder uDecoder (.inst(inst), .ctrl(ctrl));

    immGen uImm (.inst(inst), .ctrl(ctrl), .imm(imm));

    branchUnit uBranch (
        .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .imm(imm), .inst(inst), .ctrl(ctrl), .nextPc(nextPc)
    );

    stageHandshake uHandshake (
        .inValid(inValid), .trapIn(trapIn), .conflict(conflict), .flush(flush),
        .ifReady(ifReady), .exeReady(exeReady), .ctrl(ctrl),
        .ready(ready), .accept(accept), .redirect(redirect)
    );

    decodeReg uReg (
        .clk(clk), .rstN(rstN), .accept(accept), .exeReady(exeReady),
        .inst(inst), .pc(pc), .imm(imm), .ctrl(ctrl), .trapIn(trapIn),
        .stageOut(stageOut)
    );

endmodule

// ==== rtl/immGen.sv ====
`timescale 1ns/1ns
`include "rv64_macros.svh"

module immGen (
    input  logic [`INST_W-1:0]    inst,
    input  decodePkg::decodeCtrlT ctrl,
    output logic [`XLEN-1:0]      imm
);
    import decodePkg::*;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (ctrl.immFmt)
            FmtI:    imm = {{(`XLEN-12){sign}}, inst[31:20]};
            FmtS:    imm = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};
            FmtB:    imm = {{(`XLEN-13){sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            FmtU:    imm = {{(`XLEN-32){sign}}, inst[31:12], 12'b0};
            FmtJ:    imm = {{(`XLEN-21){sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// ==== rtl/instDecoder.sv ====
`timescale 1ns/1ns
`include "rv64_macros.svh"

module instDecoder (
    input  logic [`INST_W-1:0]   inst,
    output decodePkg::decodeCtrlT ctrl
);
    import decodePkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;
    logic [6:0] funct7;
    logic       shamt5;

    assign opcode = opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct6 = inst[31:26];
    assign funct7 = inst[31:25];
    assign shamt5 = inst[25];

    always_comb begin
        ctrl = '{exeOp: ExeNop, exeSrc: SrcNone, memOp: MemNop, wbSel: WbNone,
                 flow: FlowSeq, immFmt: FmtNone, trap: TrapNone};
        case (opcode)
            ////////////////////////////////////////////////////////////////////
            // Integer ALU
            OpR: begin
                ctrl.exeSrc = SrcRegReg;
                ctrl.wbSel  = WbExe;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.exeOp = Add;
                    10'b0100000_000: ctrl.exeOp = Sub;
                    10'b0000000_001: ctrl.exeOp = Sll;
                    10'b0000000_010: ctrl.exeOp = Slt;
                    10'b0000000_011: ctrl.exeOp = Sltu;
                    10'b0000000_100: ctrl.exeOp = Xor;
                    10'b0000000_101: ctrl.exeOp = Srl;
                    10'b0100000_101: ctrl.exeOp = Sra;
                    10'b0000000_110: ctrl.exeOp = Or;
                    10'b0000000_111: ctrl.exeOp = And;
                    10'b0000001_000: ctrl.exeOp = Mul;
                    10'b0000001_001: ctrl.exeOp = Mulh;
                    10'b0000001_010: ctrl.exeOp = Mulhsu;
                    10'b0000001_011: ctrl.exeOp = Mulhu;
                    10'b0000001_100: ctrl.exeOp = Div;
                    10'b0000001_101: ctrl.exeOp = Divu;
                    10'b0000001_110: ctrl.exeOp = Rem;
                    10'b0000001_111: ctrl.exeOp = Remu;
                    default:         ctrl.trap  = TrapIllegal;
                endcase
            end
            OpRW: begin
                ctrl.exeSrc = SrcRegReg;
                ctrl.wbSel  = WbExe;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.exeOp = Addw;
                    10'b0100000_000: ctrl.exeOp = Subw;
                    10'b0000000_001: ctrl.exeOp = Sllw;
                    10'b0000000_101: ctrl.exeOp = Srlw;
                    10'b0100000_101: ctrl.exeOp = Sraw;
                    10'b0000001_000: ctrl.exeOp = Mulw;
                    10'b0000001_100: ctrl.exeOp = Divw;
                    10'b0000001_101: ctrl.exeOp = Divuw;
                    10'b0000001_110: ctrl.exeOp = Remw;
                    10'b0000001_111: ctrl.exeOp = Remuw;
                    default:         ctrl.trap  = TrapIllegal;
                endcase
            end
            OpI: begin
                ctrl.exeSrc = SrcRegImm;
                ctrl.wbSel  = WbExe;
                ctrl.immFmt = FmtI;
                case (funct3)
                    3'b000: ctrl.exeOp = Add;
                    3'b010: ctrl.exeOp = Slt;
                    3'b011: ctrl.exeOp = Sltu;
                    3'b100: ctrl.exeOp = Xor;
                    3'b110: ctrl.exeOp = Or;
                    3'b111: ctrl.exeOp = And;
                    3'b001: begin
                        ctrl.exeOp = Sll;
                        if (funct6 != 6'b000000) ctrl.trap = TrapIllegal;
                    end
                    default: begin // 3'b101
                        case (funct6)
                            6'b000000: ctrl.exeOp = Srl;
                            6'b010000: ctrl.exeOp = Sra;
                            default:   ctrl.trap  = TrapIllegal;
                        endcase
                    end
                endcase
            end
            OpIW: begin
                ctrl.exeSrc = SrcRegImm;
                ctrl.wbSel  = WbExe;
                ctrl.immFmt = FmtI;
                case (funct3)
                    3'b000: ctrl.exeOp = Addw;
                    3'b001: begin
                        ctrl.exeOp = Sllw;
                        if (funct6 != 6'b000000 || shamt5) ctrl.trap = TrapIllegal;
                    end
                    3'b101: begin
                        case (funct6)
                            6'b000000: ctrl.exeOp = Srlw;
                            6'b010000: ctrl.exeOp = Sraw;
                            default:   ctrl.trap  = TrapIllegal;
                        endcase
                        if (shamt5) ctrl.trap = TrapIllegal; // Word shift is 5 bits
                    end
                    default: ctrl.trap = TrapIllegal;
                endcase
            end
            ////////////////////////////////////////////////////////////////////
            // Memory
            OpLoad: begin
                ctrl.exeOp  = Add;
                ctrl.exeSrc = SrcRegImm;
                ctrl.wbSel  = WbMem;
                ctrl.immFmt = FmtI;
                case (funct3)
                    3'b000:  ctrl.memOp = Lb;
                    3'b001:  ctrl.memOp = Lh;
                    3'b010:  ctrl.memOp = Lw;
                    3'b011:  ctrl.memOp = Ld;
                    3'b100:  ctrl.memOp = Lbu;
                    3'b101:  ctrl.memOp = Lhu;
                    3'b110:  ctrl.memOp = Lwu;
                    default: ctrl.trap  = TrapIllegal;
                endcase
            end
            OpStore: begin
                ctrl.exeOp  = Add;
                ctrl.exeSrc = SrcRegImm;
                ctrl.immFmt = FmtS;
                case (funct3)
                    3'b000:  ctrl.memOp = Sb;
                    3'b001:  ctrl.memOp = Sh;
                    3'b010:  ctrl.memOp = Sw;
                    3'b011:  ctrl.memOp = Sd;
                    default: ctrl.trap  = TrapIllegal;
                endcase
            end
            ////////////////////////////////////////////////////////////////////
            // Control flow, upper immediates, system
            OpBranch: begin
                ctrl.flow   = FlowBranch;
                ctrl.immFmt = FmtB;
                if (funct3 == 3'b010 || funct3 == 3'b011) ctrl.trap = TrapIllegal;
            end
            OpJal: begin
                ctrl.flow   = FlowJal;
                ctrl.immFmt = FmtJ;
                ctrl.wbSel  = WbNextPc;
            end
            OpJalr: begin
                ctrl.flow   = FlowJalr;
                ctrl.immFmt = FmtI;
                ctrl.wbSel  = WbNextPc;
                if (funct3 != 3'b000) ctrl.trap = TrapIllegal;
            end
            OpLui: begin
                ctrl.immFmt = FmtU;
                ctrl.wbSel  = WbImm;
            end
            OpAuipc: begin
                ctrl.exeOp  = Add;
                ctrl.exeSrc = SrcPcImm;
                ctrl.immFmt = FmtU;
                ctrl.wbSel  = WbExe;
            end
            OpSystem: begin
                case (inst[31:7])
                    25'h0000000: ctrl.trap = TrapEcall;
                    25'h0002000: ctrl.trap = TrapEbreak;
                    25'h0604000: ctrl.trap = TrapMret;
                    default:     ctrl.trap = TrapIllegal; // No CSR support
                endcase
            end
            default: ctrl.trap = TrapIllegal;
        endcase

        // A trapping word must not redirect, touch memory or write back
        if (ctrl.trap != TrapNone) begin
            ctrl.flow  = FlowSeq;
            ctrl.memOp = MemNop;
            ctrl.wbSel = WbNone;
        end
    end

endmodule

// ==== rtl/rv64_macros.svh ====
`ifndef RV64_MACROS_SVH
`define RV64_MACROS_SVH

// Data word and PC width
`define XLEN 64

// Instruction word and its fields
`define INST_W 32
`define OPCODE_W 7

// Architectural register index
`define REG_ADDR_W 5

// Fall-through PC increment
`define PC_STEP 4

`endif

// ==== rtl/stageHandshake.sv ====
`timescale 1ns/1ns

module stageHandshake (
    input  logic                  inValid,
    input  decodePkg::trapT       trapIn,
    input  logic                  conflict,
    input  logic                  flush,
    input  logic                  ifReady,
    input  logic                  exeReady,
    input  decodePkg::decodeCtrlT ctrl,
    output logic                  ready,
    output logic                  accept,
    output logic                  redirect
);
    import decodePkg::*;

    logic present;
    logic upTrap;
    logic isFlow;

    assign present = inValid && !flush; // Commit flush kills the item
    assign upTrap  = (trapIn != TrapNone);
    assign isFlow  = (ctrl.flow != FlowSeq);

    always_comb begin
        if (!present) begin
            ready  = 1'b1;
            accept = 1'b0;
        end else if (upTrap) begin
            ready  = exeReady;
            accept = exeReady;
        end else if (conflict) begin
            ready  = 1'b0;
            accept = 1'b0;
        end else begin
            ready  = exeReady && (!isFlow || ifReady); // Fetch must take the redirect
            accept = ready;
        end
    end

    assign redirect = accept && !upTrap && isFlow;

endmodule

// ==== run.sh ====
#!/bin/bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail

rm -f sim.log
verilator --binary --assert -f list.f --top-module decodeTb -o simDecode \
    && ./obj_dir/simDecode +verilator+error+limit+1000 2>&1 | tee sim.log \
    || { echo "Build or run failed"; exit 1; }

grep -q "=== FAIL ===" sim.log && exit 1 || grep -q "=== PASS ===" sim.log

// ==== tests/decodeTb.sv ====
`timescale 1ns/1ns
`include "rv64_macros.svh"

module decodeTb;
    import decodePkg::*;

    localparam int MaxCycles = 400; // Reset, directed words, 200 random and margin

    logic                   clk;
    logic                   rstN;
    logic [`INST_W-1:0]     inst;
    logic                   inValid;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    trapT                   trapIn;
    logic                   conflict, flush, ifReady, exeReady;
    logic [`REG_ADDR_W-1:0] rs1Addr, rs2Addr;
    logic                   ready, redirect;
    logic [`XLEN-1:0]       nextPc;
    stageOutT               stageOut;
    int                     seed = 57943;
    int                     cycles = 0;
    logic [31:0]            words [21];
    logic [31:0]            r;

    decodeStage dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Timeout after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // One item per cycle with given side levels
    task automatic sendWord(input logic [31:0] w, input trapT t, input logic fl,
                            input logic cf, input logic exeR);
        @(posedge clk);
        #5;
        inst     = w;
        inValid  = 1'b1;
        pc       = pc + 64'd4;
        rs1Data  = {$random(seed), $random(seed)};
        // Equal operands when inst bit 7 is set
        rs2Data  = (w[7]) ? rs1Data : {$random(seed), $random(seed)};
        trapIn   = t;
        flush    = fl;
        conflict = cf;
        exeReady = exeR;
        ifReady  = 1'b1;
    endtask

    initial begin
        words = '{32'h003100B3, 32'h403100B3, 32'h043100B3, 32'h023100B3, 32'hFFF10093,
                  32'hFFF1009B, 32'h003100BB, 32'hFF813083, 32'h00014083, 32'h00313823,
                  32'h123450B7, 32'h80000097, 32'h00310463, 32'h010000EF, 32'h004100E7,
                  32'h00000073, 32'h00100073, 32'h30200073, 32'h0201109B, 32'h00000000,
                  32'h003104E3};
        rstN = 1'b0;
        inst = '0;
        inValid = 1'b0;
        pc = 64'h8000_0000;
        rs1Data = '0;
        rs2Data = '0;
        trapIn = TrapNone;
        conflict = 1'b0;
        flush = 1'b0;
        ifReady = 1'b1;
        exeReady = 1'b1;
        repeat (10) @(posedge clk);
        #5 rstN = 1'b1;

        foreach (words[i]) sendWord(words[i], TrapNone, 1'b0, 1'b0, 1'b1);
        sendWord(32'h003100B3, TrapNone, 1'b0, 1'b0, 1'b0); // Back-pressure
        sendWord(32'h003100B3, TrapNone, 1'b0, 1'b0, 1'b0);
        sendWord(32'h00310463, TrapNone, 1'b1, 1'b0, 1'b1); // Flushed branch
        sendWord(32'h003100B3, TrapNone, 1'b0, 1'b1, 1'b1); // Hazard
        sendWord(32'h00000073, TrapIllegal, 1'b0, 1'b0, 1'b1);
        sendWord(32'h010000EF, TrapNone, 1'b0, 1'b0, 1'b1);
        #1 ifReady = 1'b0;                                    // Fetch cannot redirect

        // Random words, with legal opcodes now and then
        repeat (200) begin
            r = $random(seed);
            sendWord((r[4:3] == 0) ? words[r[28:24] % 21] : $random(seed),
                     (r[11:9] == 0) ? TrapEbreak : TrapNone,
                     r[14:12] == 0, r[17:15] == 0, r[19:18] != 0);
            ifReady = r[20] | r[21];
            inValid = r[23:22] != 0;
        end
        @(posedge clk);
        #5 inValid = 1'b0;
        repeat (3) @(posedge clk);

        $display("Run done, %0d assertion failures", dut.uAsserts.errCount);
        if (dut.uAsserts.errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tests/decode_asserts.sv ====
`timescale 1ns/1ns
`include "rv64_macros.svh"

module decodeAsserts (
    input logic                   clk,
    input logic                   rstN,
    input logic [`INST_W-1:0]     inst,
    input logic                   inValid,
    input logic [`XLEN-1:0]       pc,
    input logic [`XLEN-1:0]       rs1Data,
    input logic [`XLEN-1:0]       rs2Data,
    input decodePkg::trapT        trapIn,
    input logic                   conflict,
    input logic                   flush,
    input logic                   ifReady,
    input logic                   exeReady,
    input logic [`REG_ADDR_W-1:0] rs1Addr,
    input logic [`REG_ADDR_W-1:0] rs2Addr,
    input logic                   ready,
    input logic                   redirect,
    input logic [`XLEN-1:0]       nextPc,
    input decodePkg::stageOutT    stageOut
);
    import decodePkg::*;

    int               errCount = 0;
    logic [6:0]       op;
    logic [2:0]       f3;
    logic             present, flowOp, expReady, expAcc, expRedirect;
    logic [`XLEN-1:0] immI, immS, immB, immJ, immU, expTarget;
    logic             capRstN, capExe, capAcc;
    logic             capLive;
    logic [`INST_W-1:0] capInst;
    logic [`XLEN-1:0] capPc, capImmI, capImmS, capImmU;
    trapT             capTrap;
    memOpT            capLoadOp;
    stageOutT         capOut;

    // Load size and sign by funct3
    function automatic memOpT loadOp(input logic [2:0] f);
        case (f)
            3'b000:  return Lb;
            3'b001:  return Lh;
            3'b010:  return Lw;
            3'b011:  return Ld;
            3'b100:  return Lbu;
            3'b101:  return Lhu;
            default: return Lwu;
        endcase
    endfunction

    assign op   = inst[6:0];
    assign f3   = inst[14:12];
    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};

    // Legal branches and jumps only
    assign flowOp = (op == OpBranch && f3 != 3'b010 && f3 != 3'b011) || op == OpJal
                    || (op == OpJalr && f3 == 3'b000);
    assign present = inValid && !flush;

    always_comb begin
        if (!present) expReady = 1'b1;
        else if (trapIn != TrapNone) expReady = exeReady;
        else if (conflict) expReady = 1'b0;
        else expReady = exeReady && (!flowOp || ifReady);
        expAcc      = present && expReady;
        expRedirect = expAcc && flowOp && trapIn == TrapNone;
        if (op == OpJal) expTarget = pc + immJ;
        else if (op == OpJalr) expTarget = (rs1Data + immI) & ~64'h1;
        else begin
            case (f3)
                3'b000:  expTarget = (rs1Data == rs2Data) ? pc + immB : pc + 4;
                3'b001:  expTarget = (rs1Data != rs2Data) ? pc + immB : pc + 4;
                3'b100:  expTarget = ($signed(rs1Data) < $signed(rs2Data)) ? pc + immB : pc + 4;
                3'b101:  expTarget = ($signed(rs1Data) >= $signed(rs2Data)) ? pc + immB : pc + 4;
                3'b110:  expTarget = (rs1Data < rs2Data) ? pc + immB : pc + 4;
                default: expTarget = (rs1Data >= rs2Data) ? pc + immB : pc + 4;
            endcase
        end
    end

    // Snapshot of the edge, checked at the following falling edge
    always_ff @(posedge clk) begin
        capRstN   <= rstN;
        capExe    <= exeReady;
        capAcc    <= expAcc && exeReady;
        capInst   <= inst;
        capPc     <= pc;
        capTrap   <= trapIn;
        capImmI   <= immI;
        capImmS   <= immS;
        capImmU   <= immU;
        capLoadOp <= loadOp(f3);
        capOut    <= stageOut;
    end

    assign capLive = capAcc && capTrap == TrapNone; // Decoded item, no fetch trap

    ////////////////////////////////////////////////////////////////////
    // Handshake, redirect and register file addresses
    aReset: assert property (@(negedge clk) !(rstN && capRstN) |-> !stageOut.valid)
        else begin
            errCount++;
            $error("** Error %0t stageOut.valid exp 0 got %0d", $time, stageOut.valid);
        end
    aReady: assert property (@(negedge clk) disable iff (!rstN) ready == expReady)
        else begin
            errCount++;
            $error("** Error %0t ready exp %0d got %0d", $time, expReady, ready);
        end
    aRedir: assert property (@(negedge clk) disable iff (!rstN) redirect == expRedirect)
        else begin
            errCount++;
            $error("** Error %0t redirect exp %0d got %0d", $time, expRedirect, redirect);
        end
    aTarget: assert property (@(negedge clk) disable iff (!rstN)
                              expRedirect |-> nextPc == expTarget)
        else begin
            errCount++;
            $error("** Error %0t nextPc exp %h got %h", $time, expTarget, nextPc);
        end
    aRs1: assert property (@(negedge clk) disable iff (!rstN) rs1Addr == inst[19:15])
        else begin
            errCount++;
            $error("** Error %0t rs1Addr exp %0d got %0d", $time, inst[19:15], rs1Addr);
        end
    aRs2: assert property (@(negedge clk) disable iff (!rstN) rs2Addr == inst[24:20])
        else begin
            errCount++;
            $error("** Error %0t rs2Addr exp %0d got %0d", $time, inst[24:20], rs2Addr);
        end

    ////////////////////////////////////////////////////////////////////
    // Registered item
    aValid: assert property (@(negedge clk) disable iff (!rstN) capRstN && capExe
                             |-> stageOut.valid == capAcc)
        else begin
            errCount++;
            $error("** Error %0t stageOut.valid exp %0d got %0d", $time, capAcc,
                   stageOut.valid);
        end
    aHold: assert property (@(negedge clk) disable iff (!rstN) capRstN && !capExe
                            |-> stageOut == capOut)
        else begin
            errCount++;
            $error("** Error %0t stageOut exp %h got %h", $time, capOut, stageOut);
        end
    aPc: assert property (@(negedge clk) disable iff (!rstN) capAcc |-> stageOut.pc == capPc)
        else begin
            errCount++;
            $error("** Error %0t stageOut.pc exp %h got %h", $time, capPc, stageOut.pc);
        end
    aUpTrap: assert property (@(negedge clk) disable iff (!rstN) capAcc && capTrap != TrapNone
                              |-> stageOut.trap == capTrap)
        else begin
            errCount++;
            $error("** Error %0t stageOut.trap exp %0d got %0d", $time, capTrap,
                   stageOut.trap);
        end
    aAluWb: assert property (@(negedge clk) disable iff (!rstN) capLive
                             && capInst[6:0] == OpR && capInst[31:25] == 7'b0000000
                             |-> stageOut.wbSel == WbExe && stageOut.exeSrc == SrcRegReg)
        else begin
            errCount++;
            $error("** Error %0t stageOut.wbSel exp %0d got %0d", $time, WbExe,
                   stageOut.wbSel);
        end
    aSub: assert property (@(negedge clk) disable iff (!rstN) capLive
                           && capInst[6:0] == OpR && capInst[31:25] == 7'b0100000
                           && capInst[14:12] == 0
                           |-> stageOut.exeOp == Sub)
        else begin
            errCount++;
            $error("** Error %0t stageOut.exeOp exp %0d got %0d", $time, Sub,
                   stageOut.exeOp);
        end
    aIllegal: assert property (@(negedge clk) disable iff (!rstN) capLive
                               && capInst[6:0] == OpR && capInst[31:25] == 7'b0000010
                               |-> stageOut.trap == TrapIllegal && stageOut.valid)
        else begin
            errCount++;
            $error("** Error %0t stageOut.trap exp %0d got %0d", $time, TrapIllegal,
                   stageOut.trap);
        end
    // Word shifts take a 5-bit shamt
    aShamtW: assert property (@(negedge clk) disable iff (!rstN) capLive
                              && capInst[6:0] == OpIW && capInst[13:12] == 2'b01
                              && capInst[25]
                              |-> stageOut.trap == TrapIllegal)
        else begin
            errCount++;
            $error("** Error %0t stageOut.trap exp %0d got %0d", $time, TrapIllegal,
                   stageOut.trap);
        end
    aLoad: assert property (@(negedge clk) disable iff (!rstN) capLive
                            && capInst[6:0] == OpLoad && capInst[14:12] != 3'b111
                            |-> stageOut.imm == capImmI && stageOut.wbSel == WbMem)
        else begin
            errCount++;
            $error("** Error %0t stageOut.imm exp %h got %h", $time, capImmI, stageOut.imm);
        end
    aLoadOp: assert property (@(negedge clk) disable iff (!rstN) capLive
                              && capInst[6:0] == OpLoad && capInst[14:12] != 3'b111
                              |-> stageOut.memOp == capLoadOp)
        else begin
            errCount++;
            $error("** Error %0t stageOut.memOp exp %0d got %0d", $time, capLoadOp,
                   stageOut.memOp);
        end
    aStore: assert property (@(negedge clk) disable iff (!rstN) capLive
                             && capInst[6:0] == OpStore && capInst[14:12] == 3'b011
                             |-> stageOut.imm == capImmS && stageOut.memOp == Sd)
        else begin
            errCount++;
            $error("** Error %0t stageOut.imm exp %h got %h", $time, capImmS, stageOut.imm);
        end
    aLui: assert property (@(negedge clk) disable iff (!rstN) capLive
                           && capInst[6:0] == OpLui
                           |-> stageOut.imm == capImmU && stageOut.wbSel == WbImm)
        else begin
            errCount++;
            $error("** Error %0t stageOut.imm exp %h got %h", $time, capImmU, stageOut.imm);
        end
    aAuipc: assert property (@(negedge clk) disable iff (!rstN) capLive
                             && capInst[6:0] == OpAuipc |-> stageOut.exeSrc == SrcPcImm)
        else begin
            errCount++;
            $error("** Error %0t stageOut.exeSrc exp %0d got %0d", $time, SrcPcImm,
                   stageOut.exeSrc);
        end
    aEcall: assert property (@(negedge clk) disable iff (!rstN) capLive
                             && capInst == 32'h00000073 |-> stageOut.trap == TrapEcall)
        else begin
            errCount++;
            $error("** Error %0t stageOut.trap exp %0d got %0d", $time, TrapEcall,
                   stageOut.trap);
        end
    aEbreak: assert property (@(negedge clk) disable iff (!rstN) capLive
                              && capInst == 32'h00100073 |-> stageOut.trap == TrapEbreak)
        else begin
            errCount++;
            $error("** Error %0t stageOut.trap exp %0d got %0d", $time, TrapEbreak,
                   stageOut.trap);
        end
    aMret: assert property (@(negedge clk) disable iff (!rstN) capLive
                            && capInst == 32'h30200073 |-> stageOut.trap == TrapMret)
        else begin
            errCount++;
            $error("** Error %0t stageOut.trap exp %0d got %0d", $time, TrapMret,
                   stageOut.trap);
        end

endmodule

bind decodeStage decodeAsserts uAsserts (
    .clk(clk), .rstN(rstN), .inst(inst), .inValid(inValid), .pc(pc),
    .rs1Data(rs1Data), .rs2Data(rs2Data), .trapIn(trapIn), .conflict(conflict),
    .flush(flush), .ifReady(ifReady), .exeReady(exeReady),
    .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .ready(ready),
    .redirect(redirect), .nextPc(nextPc), .stageOut(stageOut)
);
